//--- design/noc_pkg.sv
package noc_pkg;

  // router port order, also the index into every per-port array
  typedef enum logic [2:0] {
    EAST  = 3'd0,
    WEST  = 3'd1,
    NORTH = 3'd2,
    SOUTH = 3'd3,
    LOCAL = 3'd4
  } e_port;

  localparam int NUM_PORTS   = 5;
  localparam int FLIT_WIDTH  = 16;
  localparam int COORD_WIDTH = 4;

  // first flit of a packet
  typedef struct packed {
    logic [7:0]             spare;
    logic [COORD_WIDTH-1:0] dst_x;
    logic [COORD_WIDTH-1:0] dst_y;
  } header_view_t;

  // second flit, number of payload flits that follow
  typedef struct packed {
    logic [7:0] spare;
    logic [7:0] count;
  } size_view_t;

  typedef union packed {
    logic [FLIT_WIDTH-1:0] raw;
    header_view_t          hdr;
    size_view_t            size;
  } flit_t;

endpackage

//--- design/route_if.sv
`timescale 1ns/100ps

interface route_if import noc_pkg::*; ();

  // header at buffer head waiting for an output
  logic         req;
  header_view_t dst;
  // one-cycle pulse once the connection is written
  logic         grant;
  // last flit of the packet leaves this cycle
  logic         done;

  modport port_side (
    output req,
    output dst,
    output done,
    input  grant
  );

  modport ctrl_side (
    input  req,
    input  dst,
    input  done,
    output grant
  );

endinterface

//--- design/input_buffer.sv
`timescale 1ns/100ps

module input_buffer
  import noc_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4
) (
  input  logic  clock,
  input  logic  rst_i,
  input  flit_t data_i,
  input  logic  rx_i,
  output logic  credit_o,
  output flit_t head_o,
  output logic  empty_o,
  input  logic  pop_i
);

  localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

  flit_t            mem [BUFFER_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pull;

  // pointer wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(BUFFER_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(BUFFER_DEPTH));
  assign empty_o  = (count == '0);
  assign credit_o = !full;
  assign head_o   = mem[rd_ptr];

  // sender only drives rx while credit is high
  assign push = rx_i && !full;
  assign pull = pop_i && !empty_o;

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pull) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- design/packet_counter.sv
`timescale 1ns/100ps

module packet_counter
  import noc_pkg::*;
(
  input  logic       clock,
  input  logic       rst_i,
  input  flit_t      head_i,
  input  logic       empty_i,
  input  logic       pop_i,
  route_if.port_side rt
);

  // position of the flit at the buffer head
  localparam logic [1:0] P_HEADER  = 2'd0;
  localparam logic [1:0] P_SIZE    = 2'd1;
  localparam logic [1:0] P_PAYLOAD = 2'd2;

  logic [1:0] pos;
  logic       routed;
  logic [7:0] remaining;
  logic       last_flit;

  assign rt.dst = head_i.hdr;

  // no new request between grant and the header leaving
  assign rt.req = (pos == P_HEADER) && !empty_i && !routed;

  always_comb begin
    last_flit = 1'b0;
    if (pos == P_SIZE) begin
      // empty packet ends with its size flit
      last_flit = (head_i.size.count == 8'd0);
    end else if (pos == P_PAYLOAD) begin
      last_flit = (remaining == 8'd1);
    end
  end

  assign rt.done = pop_i && last_flit;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      pos       <= P_HEADER;
      routed    <= 1'b0;
      remaining <= '0;
    end else begin
      if (rt.grant) begin
        routed <= 1'b1;
      end else if (rt.done) begin
        routed <= 1'b0;
      end
      if (pop_i) begin
        case (pos)
          P_HEADER: pos <= P_SIZE;
          P_SIZE: begin
            remaining <= head_i.size.count;
            pos       <= (head_i.size.count == 8'd0) ? P_HEADER : P_PAYLOAD;
          end
          P_PAYLOAD: begin
            remaining <= remaining - 1'b1;
            if (remaining == 8'd1) begin
              pos <= P_HEADER;
            end
          end
          default: pos <= P_HEADER;
        endcase
      end
    end
  end

endmodule

//--- design/switch_control.sv
`timescale 1ns/100ps

module switch_control
  import noc_pkg::*;
#(
  parameter int ADDR_X = 0,
  parameter int ADDR_Y = 0
) (
  input  logic                       clock,
  input  logic                       rst_i,
  route_if.ctrl_side                 rt [NUM_PORTS],
  output logic [NUM_PORTS-1:0][2:0]  conn_sel_o,
  output logic [NUM_PORTS-1:0]       conn_valid_o
);

  localparam logic [COORD_WIDTH-1:0] MY_X = COORD_WIDTH'(ADDR_X);
  localparam logic [COORD_WIDTH-1:0] MY_Y = COORD_WIDTH'(ADDR_Y);

  localparam logic [1:0] S_IDLE      = 2'd0;
  localparam logic [1:0] S_ARBITRATE = 2'd1;
  localparam logic [1:0] S_ROUTE     = 2'd2;

  logic [1:0]           state;
  logic [2:0]           sel;
  logic [2:0]           last;
  logic [2:0]           next_sel;
  logic                 found;
  logic [NUM_PORTS-1:0] req_vec;
  logic [NUM_PORTS-1:0] done_vec;
  header_view_t         dst_arr [NUM_PORTS];
  header_view_t         dst_sel;
  e_port                out_port;
  logic                 route_ok;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
    assign req_vec[i]  = rt[i].req;
    assign done_vec[i] = rt[i].done;
    assign dst_arr[i]  = rt[i].dst;
    assign rt[i].grant = (state == S_ROUTE) && route_ok && (sel == 3'(i));
  end

  // round robin, nearest requester after the last one served
  always_comb begin
    int idx;
    found    = 1'b0;
    next_sel = last;
    for (int k = NUM_PORTS; k >= 1; k--) begin
      idx = (int'(last) + k) % NUM_PORTS;
      if (req_vec[idx]) begin
        found    = 1'b1;
        next_sel = 3'(idx);
      end
    end
  end

  // XY routing, x first then y
  always_comb begin
    dst_sel = dst_arr[sel];
    if (dst_sel.dst_x > MY_X) begin
      out_port = EAST;
    end else if (dst_sel.dst_x < MY_X) begin
      out_port = WEST;
    end else if (dst_sel.dst_y > MY_Y) begin
      out_port = NORTH;
    end else if (dst_sel.dst_y < MY_Y) begin
      out_port = SOUTH;
    end else begin
      out_port = LOCAL;
    end
    route_ok = !conn_valid_o[out_port];
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state        <= S_IDLE;
      sel          <= '0;
      last         <= 3'(NUM_PORTS - 1);
      conn_sel_o   <= '0;
      conn_valid_o <= '0;
    end else begin
      // release outputs whose packet has ended
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (conn_valid_o[o] && done_vec[conn_sel_o[o]]) begin
          conn_valid_o[o] <= 1'b0;
        end
      end
      case (state)
        S_IDLE: begin
          if (|req_vec) begin
            state <= S_ARBITRATE;
          end
        end
        S_ARBITRATE: begin
          if (found) begin
            sel   <= next_sel;
            state <= S_ROUTE;
          end else begin
            state <= S_IDLE;
          end
        end
        S_ROUTE: begin
          // advance even on a busy output so others get a turn
          last <= sel;
          if (route_ok) begin
            conn_valid_o[out_port] <= 1'b1;
            conn_sel_o[out_port]   <= sel;
          end
          state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- design/crossbar.sv
`timescale 1ns/100ps

module crossbar
  import noc_pkg::*;
(
  input  logic [NUM_PORTS-1:0][2:0] conn_sel_i,
  input  logic [NUM_PORTS-1:0]      conn_valid_i,
  input  flit_t [NUM_PORTS-1:0]     head_i,
  input  logic [NUM_PORTS-1:0]      empty_i,
  input  logic [NUM_PORTS-1:0]      credit_i,
  output flit_t [NUM_PORTS-1:0]     data_o,
  output logic [NUM_PORTS-1:0]      tx_o,
  output logic [NUM_PORTS-1:0]      pop_o
);

  always_comb begin
    logic [2:0] src;
    data_o = '0;
    tx_o   = '0;
    pop_o  = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      src = conn_sel_i[o];
      if (conn_valid_i[o]) begin
        data_o[o] = head_i[src];
        // flit moves only when there is one and downstream has room
        if (!empty_i[src] && credit_i[o]) begin
          tx_o[o]    = 1'b1;
          pop_o[src] = 1'b1;
        end
      end
    end
  end

endmodule

//--- design/router.sv
`timescale 1ns/100ps

module router
  import noc_pkg::*;
#(
  parameter int ADDR_X       = 0,
  parameter int ADDR_Y       = 0,
  parameter int BUFFER_DEPTH = 4
) (
  input  logic                  clock,
  input  logic                  rst_i,
  input  flit_t [NUM_PORTS-1:0] data_i,
  input  logic [NUM_PORTS-1:0]  rx_i,
  output logic [NUM_PORTS-1:0]  credit_o,
  output flit_t [NUM_PORTS-1:0] data_o,
  output logic [NUM_PORTS-1:0]  tx_o,
  input  logic [NUM_PORTS-1:0]  credit_i
);

  flit_t [NUM_PORTS-1:0]      head;
  logic [NUM_PORTS-1:0]       empty;
  logic [NUM_PORTS-1:0]       pop;
  logic [NUM_PORTS-1:0][2:0]  conn_sel;
  logic [NUM_PORTS-1:0]       conn_valid;

  route_if rt [NUM_PORTS] ();

  // one buffer and packet tracker per input port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_input
    input_buffer #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_buffer (
      .clock    (clock),
      .rst_i    (rst_i),
      .data_i   (data_i[p]),
      .rx_i     (rx_i[p]),
      .credit_o (credit_o[p]),
      .head_o   (head[p]),
      .empty_o  (empty[p]),
      .pop_i    (pop[p])
    );

    packet_counter u_counter (
      .clock   (clock),
      .rst_i   (rst_i),
      .head_i  (head[p]),
      .empty_i (empty[p]),
      .pop_i   (pop[p]),
      .rt      (rt[p])
    );
  end

  switch_control #(
    .ADDR_X (ADDR_X),
    .ADDR_Y (ADDR_Y)
  ) u_ctrl (
    .clock        (clock),
    .rst_i        (rst_i),
    .rt           (rt),
    .conn_sel_o   (conn_sel),
    .conn_valid_o (conn_valid)
  );

  crossbar u_xbar (
    .conn_sel_i   (conn_sel),
    .conn_valid_i (conn_valid),
    .head_i       (head),
    .empty_i      (empty),
    .credit_i     (credit_i),
    .data_o       (data_o),
    .tx_o         (tx_o),
    .pop_o        (pop)
  );

endmodule

//--- design/noc_mesh.sv
`timescale 1ns/100ps

module noc_mesh
  import noc_pkg::*;
#(
  parameter int  NOC_DIM_X    = 2,
  parameter int  NOC_DIM_Y    = 2,
  parameter int  BUFFER_DEPTH = 4,
  localparam int NODES        = NOC_DIM_X * NOC_DIM_Y
) (
  input  logic              clock,
  input  logic              rst_i,
  input  flit_t [NODES-1:0] local_data_i,
  input  logic [NODES-1:0]  local_rx_i,
  output logic [NODES-1:0]  local_credit_o,
  output flit_t [NODES-1:0] local_data_o,
  output logic [NODES-1:0]  local_tx_o,
  input  logic [NODES-1:0]  local_credit_i
);

  // per node link bundles, node number is x * NOC_DIM_Y + y
  flit_t [NUM_PORTS-1:0] data_in    [NODES];
  flit_t [NUM_PORTS-1:0] data_out   [NODES];
  logic [NUM_PORTS-1:0]  rx_in      [NODES];
  logic [NUM_PORTS-1:0]  tx_out     [NODES];
  logic [NUM_PORTS-1:0]  credit_in  [NODES];
  logic [NUM_PORTS-1:0]  credit_out [NODES];

  for (genvar i = 0; i < NOC_DIM_X; i++) begin : node_x
    for (genvar j = 0; j < NOC_DIM_Y; j++) begin : node_y
      localparam int N = i * NOC_DIM_Y + j;

      router #(
        .ADDR_X       (i),
        .ADDR_Y       (j),
        .BUFFER_DEPTH (BUFFER_DEPTH)
      ) u_router (
        .clock    (clock),
        .rst_i    (rst_i),
        .data_i   (data_in[N]),
        .rx_i     (rx_in[N]),
        .credit_o (credit_out[N]),
        .data_o   (data_out[N]),
        .tx_o     (tx_out[N]),
        .credit_i (credit_in[N])
      );

      // local port straight to the top level
      assign data_in[N][LOCAL]   = local_data_i[N];
      assign rx_in[N][LOCAL]     = local_rx_i[N];
      assign credit_in[N][LOCAL] = local_credit_i[N];
      assign local_data_o[N]     = data_out[N][LOCAL];
      assign local_tx_o[N]       = tx_out[N][LOCAL];
      assign local_credit_o[N]   = credit_out[N][LOCAL];

      if (i == 0) begin : g_west_ground
        assign data_in[N][WEST]   = '0;
        assign rx_in[N][WEST]     = 1'b0;
        assign credit_in[N][WEST] = 1'b0;
      end else begin : g_west_link
        // both directions of the link to the west neighbor
        assign data_in[N][WEST]              = data_out[N-NOC_DIM_Y][EAST];
        assign rx_in[N][WEST]                = tx_out[N-NOC_DIM_Y][EAST];
        assign credit_in[N][WEST]            = credit_out[N-NOC_DIM_Y][EAST];
        assign data_in[N-NOC_DIM_Y][EAST]    = data_out[N][WEST];
        assign rx_in[N-NOC_DIM_Y][EAST]      = tx_out[N][WEST];
        assign credit_in[N-NOC_DIM_Y][EAST]  = credit_out[N][WEST];
      end

      if (i == NOC_DIM_X - 1) begin : g_east_ground
        assign data_in[N][EAST]   = '0;
        assign rx_in[N][EAST]     = 1'b0;
        assign credit_in[N][EAST] = 1'b0;
      end

      if (j == 0) begin : g_south_ground
        assign data_in[N][SOUTH]   = '0;
        assign rx_in[N][SOUTH]     = 1'b0;
        assign credit_in[N][SOUTH] = 1'b0;
      end else begin : g_south_link
        // south neighbor sits at y - 1
        assign data_in[N][SOUTH]     = data_out[N-1][NORTH];
        assign rx_in[N][SOUTH]       = tx_out[N-1][NORTH];
        assign credit_in[N][SOUTH]   = credit_out[N-1][NORTH];
        assign data_in[N-1][NORTH]   = data_out[N][SOUTH];
        assign rx_in[N-1][NORTH]     = tx_out[N][SOUTH];
        assign credit_in[N-1][NORTH] = credit_out[N][SOUTH];
      end

      if (j == NOC_DIM_Y - 1) begin : g_north_ground
        assign data_in[N][NORTH]   = '0;
        assign rx_in[N][NORTH]     = 1'b0;
        assign credit_in[N][NORTH] = 1'b0;
      end
    end
  end

endmodule

//--- bench/noc_mesh_sva.sv
`timescale 1ns/100ps

module noc_mesh_sva
  import noc_pkg::*;
(
  input logic                 clock,
  input logic                 rst_i,
  input logic [NUM_PORTS-1:0] tx_i,
  input logic [NUM_PORTS-1:0] credit_i,
  input logic [NUM_PORTS-1:0] grant_i
);

  // a flit only leaves toward a buffer with room
  tx_needs_credit: assert property (
    @(posedge clock) disable iff (rst_i) (tx_i & ~credit_i) == '0
  ) else $error("tx high without credit, tx %b credit %b", tx_i, credit_i);

  // state is cleared after the first reset edge
  tx_low_in_reset: assert property (
    @(posedge clock) (rst_i && $past(rst_i)) |-> (tx_i == '0)
  ) else $error("tx high during reset, tx %b", tx_i);

  grant_is_pulse: assert property (
    @(posedge clock) disable iff (rst_i) (grant_i != '0) |=> (grant_i == '0)
  ) else $error("grant held for two cycles, grant %b", grant_i);

endmodule

bind router noc_mesh_sva u_sva (
  .clock    (clock),
  .rst_i    (rst_i),
  .tx_i     (tx_o),
  .credit_i (credit_i),
  .grant_i  ({rt[4].grant, rt[3].grant, rt[2].grant, rt[1].grant, rt[0].grant})
);

//--- bench/noc_mesh_tb.sv
`timescale 1ns/100ps

module noc_mesh_tb
  import noc_pkg::*;
();

  localparam int NOC_DIM_X    = 2;
  localparam int NOC_DIM_Y    = 2;
  localparam int BUFFER_DEPTH = 4;
  localparam int NODES        = NOC_DIM_X * NOC_DIM_Y;
  localparam int NUM_PKTS     = 13;
  localparam int MAX_SIZE     = 8;
  localparam int NUM_PHASES   = 3;
  // destination held off while the contention phase runs
  localparam int STALL_PHASE  = 2;
  localparam int STALL_NODE   = 3;

  typedef struct {
    int phase;
    int src;
    int dst;
    int size;
  } pkt_t;

  // phase, source node, destination node, payload flits
  pkt_t pkt_table [NUM_PKTS] = '{
    '{0, 0, 3, 3}, '{0, 1, 2, 2}, '{0, 2, 1, 4}, '{0, 3, 0, 1},
    '{0, 0, 1, 2}, '{0, 2, 2, 2},
    '{1, 1, 3, 0}, '{1, 1, 3, 3}, '{1, 3, 3, 0},
    '{2, 0, 3, 4}, '{2, 1, 3, 3}, '{2, 2, 3, 5}, '{2, 3, 3, 2}
  };
  string phase_name [NUM_PHASES] = '{"xy_delivery", "empty_packet", "contention"};

  logic              clock;
  logic              rst_i;
  flit_t [NODES-1:0] local_data_i;
  logic [NODES-1:0]  local_rx_i;
  logic [NODES-1:0]  local_credit_o;
  flit_t [NODES-1:0] local_data_o;
  logic [NODES-1:0]  local_tx_o;
  logic [NODES-1:0]  local_credit_i;

  flit_t payload [NUM_PKTS][MAX_SIZE];
  bit    received [NUM_PKTS];
  int    cur_pkt [NODES];
  int    flit_pos [NODES];
  int    rx_count [NODES];
  int    delivered;
  int    cycle_count;
  int    cycle_limit;
  string test_name;

  noc_mesh #(
    .NOC_DIM_X    (NOC_DIM_X),
    .NOC_DIM_Y    (NOC_DIM_Y),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) dut (
    .clock          (clock),
    .rst_i          (rst_i),
    .local_data_i   (local_data_i),
    .local_rx_i     (local_rx_i),
    .local_credit_o (local_credit_o),
    .local_data_o   (local_data_o),
    .local_tx_o     (local_tx_o),
    .local_credit_i (local_credit_i)
  );

  always #20 clock = ~clock;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_flit(input string what, input flit_t exp, input flit_t act);
    if (exp.raw !== act.raw) begin
      report_failure($sformatf("[ERROR] %s %s: expected %h, actual %h",
                               test_name, what, exp.raw, act.raw));
    end
  endtask

  task automatic check_count(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      report_failure($sformatf("[ERROR] %s %s: expected %0d, actual %0d",
                               test_name, what, exp, act));
    end
  endtask

  task automatic check_vector(input string what, input logic [NODES-1:0] exp,
                              input logic [NODES-1:0] act);
    if (exp !== act) begin
      report_failure($sformatf("[ERROR] %s %s: expected %b, actual %b",
                               test_name, what, exp, act));
    end
  endtask

  // packet id rides in the spare header bits so the monitor can find it
  function automatic flit_t header_flit(input int id);
    flit_t f;
    f.hdr.spare = 8'(id);
    f.hdr.dst_x = COORD_WIDTH'(pkt_table[id].dst / NOC_DIM_Y);
    f.hdr.dst_y = COORD_WIDTH'(pkt_table[id].dst % NOC_DIM_Y);
    return f;
  endfunction

  function automatic flit_t size_flit(input int id);
    flit_t f;
    f.size.spare = 8'h00;
    f.size.count = 8'(pkt_table[id].size);
    return f;
  endfunction

  // called 2 ns after a rising edge, returns at the same point
  task automatic send_flit(input int node, input flit_t f);
    while (!local_credit_o[node]) begin
      @(posedge clock);
      #2;
    end
    local_data_i[node] = f;
    local_rx_i[node]   = 1'b1;
    @(posedge clock);
    #2;
    local_rx_i[node] = 1'b0;
  endtask

  task automatic inject_source(input int phase, input int node);
    @(posedge clock);
    #2;
    for (int p = 0; p < NUM_PKTS; p++) begin
      if (pkt_table[p].phase == phase && pkt_table[p].src == node) begin
        send_flit(node, header_flit(p));
        send_flit(node, size_flit(p));
        for (int k = 0; k < pkt_table[p].size; k++) begin
          send_flit(node, payload[p][k]);
        end
      end
    end
  endtask

  task automatic stall_ejection(input int node);
    int len;
    len = $urandom_range(24, 8);
    repeat (6) @(posedge clock);
    #2;
    local_credit_i[node] = 1'b0;
    repeat (len) @(posedge clock);
    #2;
    local_credit_i[node] = 1'b1;
  endtask

  task automatic take_flit(input int n, input flit_t f);
    int id;
    if (flit_pos[n] == 0) begin
      id = int'(f.hdr.spare);
      if (id >= NUM_PKTS || received[id]) begin
        report_failure($sformatf("node %0d received a header of unknown or repeated packet %0d",
                                 n, id));
      end else begin
        check_count("delivery node", 8'(pkt_table[id].dst), 8'(n));
        check_flit("header", header_flit(id), f);
        received[id] = 1'b1;
        cur_pkt[n]   = id;
        flit_pos[n]  = 1;
      end
    end else begin
      id = cur_pkt[n];
      if (flit_pos[n] == 1) begin
        check_flit("size", size_flit(id), f);
      end else begin
        check_flit($sformatf("payload %0d", flit_pos[n] - 2), payload[id][flit_pos[n] - 2], f);
      end
      flit_pos[n]++;
    end
    // wormhole keeps the packet contiguous, so it ends after size + 2 flits
    if (flit_pos[n] == pkt_table[cur_pkt[n]].size + 2) begin
      flit_pos[n] = 0;
      rx_count[n]++;
      delivered++;
    end
  endtask

  // tx and credit settle mid cycle, the flit moves on the next rising edge
  always @(negedge clock) begin
    if (!rst_i) begin
      for (int n = 0; n < NODES; n++) begin
        if (local_tx_o[n] && local_credit_i[n]) begin
          take_flit(n, local_data_o[n]);
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      report_failure($sformatf("timeout: only %0d of %0d packets delivered after %0d cycles",
                               delivered, NUM_PKTS, cycle_count));
    end
  end

  initial begin
    int target;
    int exp_count [NODES];
    clock          = 1'b0;
    rst_i          = 1'b1;
    local_data_i   = '0;
    local_rx_i     = '0;
    local_credit_i = '1;
    delivered      = 0;
    cycle_count    = 0;
    target         = 0;
    void'($urandom(32'h6e49));
    cycle_limit = 200;
    for (int p = 0; p < NUM_PKTS; p++) begin
      cycle_limit += (pkt_table[p].size + 2) * 20;
      received[p] = 1'b0;
      for (int k = 0; k < MAX_SIZE; k++) begin
        payload[p][k].raw = 16'($urandom());
      end
    end
    for (int n = 0; n < NODES; n++) begin
      cur_pkt[n]   = 0;
      flit_pos[n]  = 0;
      rx_count[n]  = 0;
      exp_count[n] = 0;
    end

    repeat (8) @(posedge clock);
    #2;
    rst_i = 1'b0;
    test_name = "reset";
    check_vector("local_tx_o", '0, local_tx_o);
    check_vector("local_credit_o", '1, local_credit_o);

    for (int ph = 0; ph < NUM_PHASES; ph++) begin
      test_name = phase_name[ph];
      for (int p = 0; p < NUM_PKTS; p++) begin
        if (pkt_table[p].phase == ph) begin
          target++;
          exp_count[pkt_table[p].dst]++;
        end
      end
      // every source starts on the same edge
      for (int s = 0; s < NODES; s++) begin
        fork
          automatic int node  = s;
          automatic int phase = ph;
          inject_source(phase, node);
        join_none
      end
      if (ph == STALL_PHASE) begin
        fork
          stall_ejection(STALL_NODE);
        join_none
      end
      while (delivered < target) begin
        @(posedge clock);
      end
    end

    // idle a while so a stray or duplicated flit still shows up
    repeat (20) @(posedge clock);
    test_name = "packet_count";
    for (int n = 0; n < NODES; n++) begin
      check_count($sformatf("node %0d", n), 8'(exp_count[n]), 8'(rx_count[n]));
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- sources.f
design/noc_pkg.sv
design/route_if.sv
design/input_buffer.sv
design/packet_counter.sv
design/switch_control.sv
design/crossbar.sv
design/router.sv
design/noc_mesh.sv
bench/noc_mesh_sva.sv
bench/noc_mesh_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert
TOP         = noc_mesh_tb
FILELIST    = sources.f
OBJ_DIR     = obj_dir
LOG         = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail, the pipe hides the exit code
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
